// File: mxu.f
hw/mxu_fmt_pkg.sv
hw/mxu_geom_pkg.sv
hw/mxu_feed_if.sv
hw/mxu_mac_cell.sv
hw/mxu_skew_buffer.sv
hw/mxu_array.sv
hw/mxu_core.sv
tb/tb_clk_gen.sv
tb/tb_mxu_core.sv

// File: Bender.yml
package:
  name: mxu

sources:
  - hw/mxu_fmt_pkg.sv
  - hw/mxu_geom_pkg.sv
  - hw/mxu_feed_if.sv
  - hw/mxu_mac_cell.sv
  - hw/mxu_skew_buffer.sv
  - hw/mxu_array.sv
  - hw/mxu_core.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_mxu_core.sv

// File: tb/tb_mxu_core.sv
`timescale 1ns/1ps

module tb_mxu_core
    import mxu_fmt_pkg::*;
    import mxu_geom_pkg::*;
();

    localparam int K   = K_DEFAULT;
    localparam int M   = M_DEFAULT;
    localparam int W   = WIDTH_DEFAULT;
    localparam int lat = K + M;

    typedef struct packed {
        int             due;
        logic [M*W-1:0] y;
    } expect_t;

    logic             clk;
    logic             arst_n;
    logic             enable;
    data_type_e       data_type;
    logic [K*W-1:0]   input_data;
    logic [M*W-1:0]   weight;
    logic             weight_load;
    logic [M*W-1:0]   y;
    logic             y_valid;

    logic [W-1:0]     w_mat [K][M];
    logic [31:0]      lfsr_state = 32'h818d13a1;
    expect_t          exp_q [$];
    int               cycle_cnt = 0;
    int               value_errors = 0;
    int               valid_errors = 0;
    int               hold_errors = 0;
    int               timeouts = 0;
    logic [M*W-1:0]   last_y;
    logic             have_last = 1'b0;

    tb_clk_gen #(.period_ns(4.0)) u_clk_gen (.clk(clk));

    mxu_core #(.M(M), .K(K), .data_width(W)) UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .enable      (enable),
        .data_type   (data_type),
        .input_data  (input_data),
        .weight      (weight),
        .weight_load (weight_load),
        .y           (y),
        .y_valid     (y_valid)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    function automatic int lane_value(input logic [W-1:0] lane, input data_type_e fmt);
        logic signed [3:0]   nib;
        logic signed [W-1:0] full;
        nib  = lane[3:0];
        full = lane;
        case (fmt)
            uint8:   return int'(lane);
            int4:    return int'(nib);
            default: return int'(full);
        endcase
    endfunction

    function automatic logic [W-1:0] clamp_lane(input int sum, input data_type_e fmt);
        int hi;
        int lo;
        int res;
        case (fmt)
            uint8: begin
                hi = 255;
                lo = 0;
            end
            int4: begin
                hi = 7;
                lo = -8;
            end
            default: begin
                hi = 127;
                lo = -128;
            end
        endcase
        res = (sum > hi) ? hi : ((sum < lo) ? lo : sum);
        return W'(res);
    endfunction

    function automatic logic [M*W-1:0] expected_y(input logic [K*W-1:0] x, input data_type_e fmt);
        logic [M*W-1:0] res;
        int             sum;
        for (int m = 0; m < M; m++) begin
            sum = 0;
            for (int k = 0; k < K; k++) begin
                sum += lane_value(x[k*W +: W], fmt) * lane_value(w_mat[k][m], fmt);
            end
            res[m*W +: W] = clamp_lane(sum, fmt);
        end
        return res;
    endfunction

    ////////////////////
    // Stimulus tasks
    ////////////////////

    // Bottom row goes in first so the last strobe lands in row 0
    task automatic load_weights();
        for (int r = K - 1; r >= 0; r--) begin
            @(negedge clk);
            enable      = 1'b0;
            weight_load = 1'b1;
            for (int m = 0; m < M; m++) begin
                weight[m*W +: W] = w_mat[r][m];
            end
        end
        @(negedge clk);
        weight_load = 1'b0;
    endtask

    task automatic send_vector(input logic [K*W-1:0] x);
        expect_t e;
        @(negedge clk);
        enable     = 1'b1;
        input_data = x;
        e.due      = cycle_cnt + 1 + lat;
        e.y        = expected_y(x, data_type);
        exp_q.push_back(e);
    endtask

    // Idle lanes carry junk that must be ignored
    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            enable     = 1'b0;
            input_data = take_bits(K * W);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 4 * lat) begin
            @(negedge clk);
            enable = 1'b0;
            n++;
        end
        if (exp_q.size() > 0) begin
            timeouts++;
            $display("Timeout: %0d results still missing after %0d cycles", exp_q.size(), n);
        end
    endtask

    // Cycles from the sampling edge until y_valid
    task automatic measure_latency(output int cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            enable = 1'b0;
            n++;
        end while (!y_valid && n < 4 * lat);
        if (!y_valid) begin
            timeouts++;
            $display("Timeout: y_valid never rose after %0d cycles", n);
        end
        cycles = n - 1;
    endtask

    ////////////////////
    // Output checks
    ////////////////////

    always @(negedge clk) begin : check_outputs
        logic due_now;
        if (arst_n) begin
            due_now = (exp_q.size() > 0) && (exp_q[0].due == cycle_cnt);
            assert (y_valid === due_now) else begin
                valid_errors++;
                $display("[ERROR] %t: y_valid is %b, expected %b", $time, y_valid, due_now);
            end
            if (due_now) begin
                assert (y === exp_q[0].y) else begin
                    value_errors++;
                    $display("[ERROR] %t: y is %h, expected %h", $time, y, exp_q[0].y);
                end
                void'(exp_q.pop_front());
            end
            if (y_valid) begin
                last_y    = y;
                have_last = 1'b1;
            end else if (have_last) begin
                assert (y === last_y) else begin
                    hold_errors++;
                    $display("[ERROR] %t: y changed to %h while idle", $time, y);
                end
            end
        end
    end

    initial begin : run_tests
        int lat_seen;
        $timeformat(-9, 0, " ns", 0);
        arst_n      = 1'b0;
        enable      = 1'b0;
        data_type   = int8;
        input_data  = '0;
        weight      = '0;
        weight_load = 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        arst_n = 1'b1;

        // Quiet after reset
        idle_cycles(2 * lat);

        // Identity weights with the first vector timing the latency
        for (int k = 0; k < K; k++) begin
            for (int m = 0; m < M; m++) begin
                w_mat[k][m] = (k == m) ? 8'd1 : 8'd0;
            end
        end
        load_weights();
        send_vector(32'h80_7F_01_FF);
        measure_latency(lat_seen);
        assert (lat_seen == lat) else begin
            value_errors++;
            $display("[ERROR] %t: latency %0d cycles, expected %0d", $time, lat_seen, lat);
        end
        for (int i = 0; i < 4; i++) begin
            send_vector(take_bits(K * W));
        end
        wait_drain();

        // Signed saturation at both ends
        for (int k = 0; k < K; k++) begin
            for (int m = 0; m < M; m++) begin
                w_mat[k][m] = (m == 3) ? 8'h80 : 8'h7F;
            end
        end
        load_weights();
        send_vector({4{8'h7F}});
        send_vector({4{8'h80}});
        send_vector(32'h00_00_00_01);
        wait_drain();

        // Unsigned with mixed weights
        data_type = uint8;
        for (int k = 0; k < K; k++) begin
            for (int m = 0; m < M; m++) begin
                w_mat[k][m] = ((k + m) % 2 == 1) ? W'(take_bits(W)) : W'(k);
            end
        end
        load_weights();
        send_vector({4{8'hFF}});
        send_vector('0);
        send_vector(32'h01_00_02_01);
        for (int i = 0; i < 3; i++) begin
            send_vector(take_bits(K * W));
        end
        wait_drain();

        // Nibble operands with junk in the upper half
        data_type = int4;
        for (int k = 0; k < K; k++) begin
            for (int m = 0; m < M; m++) begin
                w_mat[k][m] = W'(take_bits(W));
            end
        end
        load_weights();
        send_vector({4{8'hA7}});
        send_vector(32'h58_F8_38_08);
        for (int i = 0; i < 4; i++) begin
            send_vector(take_bits(K * W));
        end
        wait_drain();

        // Random stream with random gaps
        data_type = int8;
        for (int k = 0; k < K; k++) begin
            for (int m = 0; m < M; m++) begin
                w_mat[k][m] = W'(take_bits(W));
            end
        end
        load_weights();
        for (int i = 0; i < 30; i++) begin
            send_vector(take_bits(K * W));
            if (take_bits(1) == 1) begin
                idle_cycles(1 + take_bits(2));
            end
        end
        wait_drain();

        $display("Errors: %0d value, %0d valid, %0d hold, %0d timeout",
                 value_errors, valid_errors, hold_errors, timeouts);
        if (value_errors + valid_errors + hold_errors + timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns = 4.0
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

endmodule

// File: hw/mxu_core.sv
`timescale 1ns/1ps

module mxu_core
    import mxu_fmt_pkg::*;
    import mxu_geom_pkg::*;
#(
    parameter int M          = M_DEFAULT,
    parameter int K          = K_DEFAULT,
    parameter int data_width = WIDTH_DEFAULT
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      enable,
    input  data_type_e                data_type,
    input  logic [K*data_width-1:0]   input_data,
    input  logic [M*data_width-1:0]   weight,
    input  logic                      weight_load,
    output logic [M*data_width-1:0]   y,
    output logic                      y_valid
);

    localparam int acc_w = calc_acc_width(data_width, K);
    localparam int lat   = K + M;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] data;
    } act_lane_t;

    typedef logic signed [acc_w-1:0] acc_t;

    act_lane_t  in_q       [K];
    act_lane_t  act_skewed [K];
    acc_t       col_sum    [M];
    acc_t       col_align  [M];
    logic [lat-1:0] valid_sr;

    mxu_feed_if #(.K(K), .M(M), .data_width(data_width)) feed ();

    ////////////////////
    // Input side
    ////////////////////

    // Sampling edge, lanes enter the skew triangle from here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < K; k++) begin
                in_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < K; k++) begin
                in_q[k].valid <= enable;
                in_q[k].data  <= input_data[k*data_width +: data_width];
            end
        end
    end

    mxu_skew_buffer #(
        .lanes      (K),
        .payload_t  (act_lane_t),
        .descending (1'b0)
    ) u_in_skew (
        .clk    (clk),
        .arst_n (arst_n),
        .din    (in_q),
        .dout   (act_skewed)
    );

    for (genvar k = 0; k < K; k++) begin : g_feed_act
        assign feed.act_valid[k] = act_skewed[k].valid;
        assign feed.act[k]       = act_skewed[k].data;
    end

    for (genvar m = 0; m < M; m++) begin : g_feed_w
        assign feed.weight[m] = weight[m*data_width +: data_width];
    end

    assign feed.weight_load = weight_load;
    assign feed.fmt         = data_type;

    mxu_array #(
        .K          (K),
        .M          (M),
        .data_width (data_width)
    ) u_array (
        .clk      (clk),
        .arst_n   (arst_n),
        .feed     (feed),
        .psum_out (col_sum)
    );

    ////////////////////
    // Output side
    ////////////////////

    // Later columns finish later, so earlier ones wait longer
    mxu_skew_buffer #(
        .lanes      (M),
        .payload_t  (acc_t),
        .descending (1'b1)
    ) u_out_deskew (
        .clk    (clk),
        .arst_n (arst_n),
        .din    (col_sum),
        .dout   (col_align)
    );

    // Valid tracks the vector from the sampling register to y
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[lat-2:0], in_q[0].valid};
        end
    end

    assign y_valid = valid_sr[lat-1];

    // Saturate into the lane width, hold between vectors
    always_ff @(posedge clk) begin
        if (valid_sr[lat-2]) begin
            for (int m = 0; m < M; m++) begin
                y[m*data_width +: data_width] <=
                    data_width'(saturate(col_align[m], data_type, data_width));
            end
        end
    end

endmodule

// File: hw/mxu_array.sv
`timescale 1ns/1ps

module mxu_array
    import mxu_geom_pkg::*;
#(
    parameter  int K          = K_DEFAULT,
    parameter  int M          = M_DEFAULT,
    parameter  int data_width = WIDTH_DEFAULT,
    localparam int acc_w      = calc_acc_width(data_width, K)
) (
    input  logic                    clk,
    input  logic                    arst_n,
    mxu_feed_if.array               feed,
    output logic signed [acc_w-1:0] psum_out [M]
);

    // Weights run down the columns
    logic [data_width-1:0]   w_chain [K+1][M];

    // Activations run along the rows
    logic [data_width-1:0]   act_chain [K][M+1];

    // Partial sums run down the columns
    logic signed [acc_w-1:0] psum_chain [K+1][M];

    ////////////////////
    // Grid edges
    ////////////////////

    for (genvar m = 0; m < M; m++) begin : g_col_edge
        assign w_chain[0][m]    = feed.weight[m];
        assign psum_chain[0][m] = '0;
        assign psum_out[m]      = psum_chain[K][m];
    end

    // Idle lanes feed zero so empty slots add nothing
    for (genvar k = 0; k < K; k++) begin : g_row_edge
        assign act_chain[k][0] = feed.act_valid[k] ? feed.act[k] : '0;
    end

    ////////////////////
    // Cell grid
    ////////////////////

    for (genvar k = 0; k < K; k++) begin : g_row
        for (genvar m = 0; m < M; m++) begin : g_col
            mxu_mac_cell #(
                .data_width (data_width),
                .acc_width  (acc_w),
                .load_first (k == 0)
            ) u_cell (
                .clk         (clk),
                .arst_n      (arst_n),
                .fmt         (feed.fmt),
                .weight_load (feed.weight_load),
                .weight_in   (w_chain[k][m]),
                .weight_out  (w_chain[k+1][m]),
                .act_in      (act_chain[k][m]),
                .act_out     (act_chain[k][m+1]),
                .psum_in     (psum_chain[k][m]),
                .psum_out    (psum_chain[k+1][m])
            );
        end
    end

endmodule

// File: hw/mxu_skew_buffer.sv
`timescale 1ns/1ps

module mxu_skew_buffer #(
    parameter int  lanes      = 4,
    parameter type payload_t  = logic [7:0],
    parameter bit  descending = 1'b0
) (
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t din  [lanes],
    output payload_t dout [lanes]
);

    // Delay triangle, lane i gets i stages or lanes-1-i when descending
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        localparam int depth = descending ? (lanes - 1 - i) : i;

        if (depth == 0) begin : g_pass
            assign dout[i] = din[i];
        end else begin : g_delay
            payload_t pipe [depth];

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    for (int s = 0; s < depth; s++) begin
                        pipe[s] <= '0;
                    end
                end else begin
                    pipe[0] <= din[i];
                    for (int s = 1; s < depth; s++) begin
                        pipe[s] <= pipe[s-1];
                    end
                end
            end

            assign dout[i] = pipe[depth-1];
        end
    end

endmodule

// File: hw/mxu_mac_cell.sv
`timescale 1ns/1ps

module mxu_mac_cell
    import mxu_fmt_pkg::*;
    import mxu_geom_pkg::*;
#(
    parameter int data_width = WIDTH_DEFAULT,
    parameter int acc_width  = calc_acc_width(WIDTH_DEFAULT, K_DEFAULT),
    parameter bit load_first = 1'b0
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  data_type_e                  fmt,
    input  logic                        weight_load,
    input  logic [data_width-1:0]       weight_in,
    output logic [data_width-1:0]       weight_out,
    input  logic [data_width-1:0]       act_in,
    output logic [data_width-1:0]       act_out,
    input  logic signed [acc_width-1:0] psum_in,
    output logic signed [acc_width-1:0] psum_out
);

    logic [data_width-1:0]       weight_q;
    logic signed [data_width:0]  w_ext;
    logic signed [data_width:0]  a_ext;
    logic signed [2*data_width+1:0] product;
    logic signed [acc_width-1:0] psum_base;

    // Stationary weight, shifted down the column on each load strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weight_q <= '0;
        end else if (weight_load) begin
            weight_q <= weight_in;
        end
    end

    assign weight_out = weight_q;

    ////////////////////
    // Multiply and add
    ////////////////////

    assign w_ext = (data_width + 1)'(extend_operand(weight_q, fmt, data_width));
    assign a_ext = (data_width + 1)'(extend_operand(act_in, fmt, data_width));
    assign product = w_ext * a_ext;

    // Top row starts the column sum
    assign psum_base = load_first ? '0 : psum_in;

    // Activation moves one column right per cycle
    always_ff @(posedge clk) begin
        act_out  <= act_in;
        psum_out <= psum_base + product;
    end

endmodule

// File: hw/mxu_feed_if.sv
`timescale 1ns/1ps

interface mxu_feed_if
    import mxu_fmt_pkg::*;
    import mxu_geom_pkg::*;
#(
    parameter int K          = K_DEFAULT,
    parameter int M          = M_DEFAULT,
    parameter int data_width = WIDTH_DEFAULT
) ();

    // Per-lane valid, already skewed like the lanes themselves
    logic [K-1:0]            act_valid;
    logic [data_width-1:0]   act [K];

    // One strobe shifts every weight row down by one
    logic                    weight_load;
    logic [data_width-1:0]   weight [M];

    data_type_e              fmt;

    modport feeder (
        output act_valid,
        output act,
        output weight_load,
        output weight,
        output fmt
    );

    modport array (
        input act_valid,
        input act,
        input weight_load,
        input weight,
        input fmt
    );

endinterface

// File: hw/mxu_geom_pkg.sv
package mxu_geom_pkg;

    ////////////////////
    // Default array size
    ////////////////////

    // Output columns
    localparam int M_DEFAULT = 4;

    // Input lanes, also the number of grid rows
    localparam int K_DEFAULT = 4;

    // Lane width in bits
    localparam int WIDTH_DEFAULT = 8;

    ////////////////////
    // Derived widths
    ////////////////////

    // Product of two widened operands plus growth over K rows
    function automatic int calc_acc_width(
        input int data_width,
        input int k
    );
        return 2 * data_width + 2 + $clog2(k);
    endfunction

endpackage

// File: hw/mxu_fmt_pkg.sv
package mxu_fmt_pkg;

    // Operand format select, codes outside the list decode as int8
    typedef enum logic [4:0] {
        int8  = 5'd0,
        uint8 = 5'd1,
        int4  = 5'd2
    } data_type_e;

    // Widest lane and widest sum the helpers accept
    localparam int max_lane_w = 32;
    localparam int max_sum_w  = 96;

    // Widen one lane to a signed value, one bit wider than the lane
    function automatic logic signed [max_lane_w:0] extend_operand(
        input logic [max_lane_w-1:0] lane,
        input data_type_e            fmt,
        input int unsigned           width
    );
        int unsigned             nb;
        logic                    is_signed;
        logic [max_lane_w:0]     res;
        nb        = (fmt == int4) ? 4 : width;
        is_signed = (fmt != uint8);
        res       = '0;
        for (int i = 0; i < max_lane_w; i++) begin
            if (i < nb) begin
                res[i] = lane[i];
            end else begin
                res[i] = is_signed & lane[nb-1];
            end
        end
        res[max_lane_w] = is_signed & lane[nb-1];
        return signed'(res);
    endfunction

    // Clamp a wide sum into the range of the format
    function automatic logic signed [max_lane_w-1:0] saturate(
        input logic signed [max_sum_w-1:0] sum,
        input data_type_e                  fmt,
        input int unsigned                 width
    );
        logic signed [max_sum_w-1:0] one;
        logic signed [max_sum_w-1:0] hi;
        logic signed [max_sum_w-1:0] lo;
        logic signed [max_sum_w-1:0] res;
        one = 1;
        case (fmt)
            uint8: begin
                hi = (one << width) - one;
                lo = '0;
            end
            int4: begin
                hi = (one << 3) - one;
                lo = -(one << 3);
            end
            default: begin
                hi = (one << (width - 1)) - one;
                lo = -(one << (width - 1));
            end
        endcase
        if (sum > hi) begin
            res = hi;
        end else if (sum < lo) begin
            res = lo;
        end else begin
            res = sum;
        end
        return max_lane_w'(res);
    endfunction

endpackage
